// ==== logic/mem_fifo_pkg.sv ====
// DDR2 FIFO side definitions
package mem_fifo_pkg;

   // **************************************************
   // field widths of the DDR2 FIFOs
   // **************************************************

   // address as seen by the memory controller
   localparam int ADDR_W = 31;
   // one write-data beat
   localparam int DATA_W = 128;
   // one mask bit per data byte
   localparam int MASK_W = DATA_W / 8;
   // command code field of the address FIFO
   localparam int CMD_W  = 3;

   // command codes understood by the controller
   localparam logic [CMD_W-1:0] CMD_WRITE = 3'd0;
   localparam logic [CMD_W-1:0] CMD_READ  = 3'd1;

   // **************************************************
   // FIFO entries and client requests
   // **************************************************

   // one address FIFO entry, 34 bits
   typedef struct packed {
      logic [CMD_W-1:0]  cmd;
      logic [ADDR_W-1:0] addr;
   } ddr_cmd_t;

   // one write-data FIFO entry, 144 bits
   // a set mask bit keeps that byte from being written
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [MASK_W-1:0] mask;
   } ddr_wdata_t;

   // full read/write path of a cache, 180 bits
   typedef struct packed {
      logic       af_wr_en;
      logic       wdf_wr_en;
      ddr_cmd_t   cmd;
      ddr_wdata_t wdata;
   } cache_req_t;

   // write-only path of the line engine, 177 bits
   // the command is always a write so only the address travels
   typedef struct packed {
      logic              af_wr_en;
      logic              wdf_wr_en;
      logic [ADDR_W-1:0] addr;
      ddr_wdata_t        wdata;
   } line_req_t;

   // read-only path of the pixel feeder, 32 bits
   typedef struct packed {
      logic              af_wr_en;
      logic [ADDR_W-1:0] addr;
   } pixel_req_t;

endpackage

// ==== logic/arb_client_pkg.sv ====
// Arbiter client and read ticket definitions
package arb_client_pkg;

   // **************************************************
   // clients sharing the DDR2 FIFOs
   // **************************************************

   // grant value, listed in falling priority after NONE
   // NONE means nobody holds the FIFOs this cycle
   typedef enum logic [2:0] {
      NONE   = 3'd0,
      ICACHE = 3'd1,
      DCACHE = 3'd2,
      PIXEL  = 3'd3,
      LINE   = 3'd4
   } client_t;

   // **************************************************
   // read return bookkeeping
   // **************************************************

   // issue count width
   // wider than the read FIFO is deep, so a wrapped count
   // never aliases a read still in flight
   localparam int TICKET_W = 11;

   // every read comes back as this many beats
   localparam int BEATS_PER_READ = 2;

   // shift that turns a beat count into a read count
   localparam int BEAT_SHIFT = $clog2(BEATS_PER_READ);

   // serviced counter counts beats, one extra bit per halving
   localparam int SERVICED_W = TICKET_W + BEAT_SHIFT;

   // remaining-beat counter inside a ticket
   // must hold the value BEATS_PER_READ itself
   localparam int BEAT_CNT_W = $clog2(BEATS_PER_READ + 1);

endpackage

// ==== logic/fifo_grant_select.sv ====
// FIFO grant and request mux
`timescale 1ns/1ps

module fifo_grant_select
   import mem_fifo_pkg::*, arb_client_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // DDR2 FIFO status
   input  logic       i_af_full,
   input  logic       i_wdf_full,
   // client requests
   input  cache_req_t i_icache_req,
   input  cache_req_t i_dcache_req,
   input  pixel_req_t i_pixel_req,
   input  line_req_t  i_line_req,
   // who holds the FIFOs this cycle
   output client_t    o_grant,
   // to the DDR2 FIFOs
   output ddr_cmd_t   o_cmd,
   output logic       o_af_wr_en,
   output ddr_wdata_t o_wdata,
   output logic       o_wdf_wr_en,
   // pulse for every accepted read command
   output logic       o_read_issued,
   // per-client full flags
   output logic       o_icache_full,
   output logic       o_dcache_full,
   output logic       o_pixel_full,
   output logic       o_line_full
);

   // cmd and data go in together so both FIFOs need room
   logic fifo_ok;
   // set between the two beats of a line burst
   logic line_rsv;
   logic line_beat_acc;
   // enables of the granted client before full gating
   logic af_req;
   logic wdf_req;
   logic icache_wants;
   logic dcache_wants;
   logic pixel_wants;
   logic line_wants;

   // full flag is low only for the granted client with room in both FIFOs
   function automatic logic client_full(input client_t grant, input logic room,
                                        input client_t who);
      return !(grant == who && room);
   endfunction

   assign fifo_ok = !i_af_full && !i_wdf_full;

   assign icache_wants = i_icache_req.af_wr_en || i_icache_req.wdf_wr_en;
   assign dcache_wants = i_dcache_req.af_wr_en || i_dcache_req.wdf_wr_en;
   assign pixel_wants  = i_pixel_req.af_wr_en;
   assign line_wants   = i_line_req.af_wr_en || i_line_req.wdf_wr_en;

   // **************************************************
   // priority grant
   // **************************************************

   // icache, dcache, pixel, line
   // an open line burst locks out everyone else
   always_comb begin
      if (!line_rsv && icache_wants) begin
         o_grant = ICACHE;
      end else if (!line_rsv && dcache_wants) begin
         o_grant = DCACHE;
      end else if (!line_rsv && pixel_wants) begin
         o_grant = PIXEL;
      end else if (line_wants) begin
         o_grant = LINE;
      end else begin
         o_grant = NONE;
      end
   end

   // **************************************************
   // FIFO output mux
   // **************************************************

   always_comb begin
      // idle default is the icache payload with no enables
      o_cmd   = i_icache_req.cmd;
      o_wdata = i_icache_req.wdata;
      af_req  = 1'b0;
      wdf_req = 1'b0;
      case (o_grant)
         ICACHE: begin
            o_cmd   = i_icache_req.cmd;
            o_wdata = i_icache_req.wdata;
            af_req  = i_icache_req.af_wr_en;
            wdf_req = i_icache_req.wdf_wr_en;
         end
         DCACHE: begin
            o_cmd   = i_dcache_req.cmd;
            o_wdata = i_dcache_req.wdata;
            af_req  = i_dcache_req.af_wr_en;
            wdf_req = i_dcache_req.wdf_wr_en;
         end
         PIXEL: begin
            // read only so the data FIFO is never written
            o_cmd.cmd     = CMD_READ;
            o_cmd.addr    = i_pixel_req.addr;
            o_wdata.data  = '0;
            o_wdata.mask  = '1;
            af_req        = i_pixel_req.af_wr_en;
         end
         LINE: begin
            // write only
            o_cmd.cmd  = CMD_WRITE;
            o_cmd.addr = i_line_req.addr;
            o_wdata    = i_line_req.wdata;
            af_req     = i_line_req.af_wr_en;
            wdf_req    = i_line_req.wdf_wr_en;
         end
         default: begin
         end
      endcase
   end

   // nothing enters either FIFO unless both have room
   assign o_af_wr_en  = af_req && fifo_ok;
   assign o_wdf_wr_en = wdf_req && fifo_ok;

   // read command actually written this cycle
   assign o_read_issued = o_af_wr_en && (o_cmd.cmd == CMD_READ);

   // **************************************************
   // line burst reservation
   // **************************************************

   assign line_beat_acc = (o_grant == LINE) && fifo_ok;

   // first beat sets and second beat clears
   always_ff @(posedge clk) begin
      if (rst) begin
         line_rsv <= 1'b0;
      end else if (line_beat_acc) begin
         line_rsv <= !line_rsv;
      end
   end

   // per-client full flags
   assign o_icache_full = client_full(o_grant, fifo_ok, ICACHE);
   assign o_dcache_full = client_full(o_grant, fifo_ok, DCACHE);
   assign o_pixel_full  = client_full(o_grant, fifo_ok, PIXEL);
   assign o_line_full   = client_full(o_grant, fifo_ok, LINE);

endmodule

// ==== logic/read_ticket.sv ====
// Outstanding read ticket
`timescale 1ns/1ps

module read_ticket
   import arb_client_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   // capture the current issue number
   input  logic                i_claim,
   input  logic [TICKET_W-1:0] i_issue_num,
   // read number of the beat now at the head of the read FIFO
   input  logic [TICKET_W-1:0] i_serviced_num,
   input  logic                i_rdf_valid,
   // this ticket owns the current beat
   output logic                o_owns
);

   // issue number of the outstanding read
   logic [TICKET_W-1:0]   ticket_num;
   // beats still to come back, zero means no read pending
   logic [BEAT_CNT_W-1:0] beats_left;

   assign o_owns = (beats_left != '0) && (ticket_num == i_serviced_num);

   always_ff @(posedge clk) begin
      if (rst) begin
         ticket_num <= '0;
         beats_left <= '0;
      end else if (i_claim) begin
         // new read replaces the old ticket
         ticket_num <= i_issue_num;
         beats_left <= BEAT_CNT_W'(BEATS_PER_READ);
      end else if (o_owns && i_rdf_valid) begin
         // one of our beats went by
         beats_left <= beats_left - 1'b1;
      end
   end

endmodule

// ==== logic/read_return_router.sv ====
// Read return routing by ticket
`timescale 1ns/1ps

module read_return_router
   import arb_client_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   // from the grant select
   input  client_t i_grant,
   input  logic    i_read_issued,
   // DDR2 read FIFO
   input  logic    i_rdf_valid,
   output logic    o_rdf_rd_en,
   // client read enables
   input  logic    i_icache_rdf_rd_en,
   input  logic    i_dcache_rdf_rd_en,
   input  logic    i_pixel_rdf_rd_en,
   // client read valids
   output logic    o_icache_rdf_valid,
   output logic    o_dcache_rdf_valid,
   output logic    o_pixel_rdf_valid
);

   // reads written to the address FIFO so far
   logic [TICKET_W-1:0]   issue_cnt;
   // beats returned so far
   logic [SERVICED_W-1:0] serviced_cnt;
   // read number the current beat belongs to
   logic [TICKET_W-1:0]   serviced_num;
   logic                  icache_claim;
   logic                  dcache_claim;
   logic                  icache_owns;
   logic                  dcache_owns;

   // **************************************************
   // issue and service counters
   // **************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         issue_cnt    <= '0;
         serviced_cnt <= '0;
      end else begin
         if (i_read_issued) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (i_rdf_valid) begin
            serviced_cnt <= serviced_cnt + 1'b1;
         end
      end
   end

   // beat count over beats per read
   assign serviced_num = TICKET_W'(serviced_cnt >> BEAT_SHIFT);

   // a cache claims its ticket when its own read goes in
   assign icache_claim = (i_grant == ICACHE) && i_read_issued;
   assign dcache_claim = (i_grant == DCACHE) && i_read_issued;

   read_ticket icache_ticket_inst (
      .clk            (clk),
      .rst            (rst),
      .i_claim        (icache_claim),
      .i_issue_num    (issue_cnt),
      .i_serviced_num (serviced_num),
      .i_rdf_valid    (i_rdf_valid),
      .o_owns         (icache_owns)
   );

   read_ticket dcache_ticket_inst (
      .clk            (clk),
      .rst            (rst),
      .i_claim        (dcache_claim),
      .i_issue_num    (issue_cnt),
      .i_serviced_num (serviced_num),
      .i_rdf_valid    (i_rdf_valid),
      .o_owns         (dcache_owns)
   );

   // **************************************************
   // beat routing
   // **************************************************

   // unclaimed beats belong to the pixel feeder
   assign o_rdf_rd_en = icache_owns ? i_icache_rdf_rd_en :
                        dcache_owns ? i_dcache_rdf_rd_en :
                        i_pixel_rdf_rd_en;

   assign o_icache_rdf_valid = i_rdf_valid && icache_owns;
   assign o_dcache_rdf_valid = i_rdf_valid && dcache_owns && !icache_owns;
   assign o_pixel_rdf_valid  = i_rdf_valid && !icache_owns && !dcache_owns;

endmodule

// ==== logic/ddr_request_arbiter.sv ====
// DDR2 request arbiter
`timescale 1ns/1ps

module ddr_request_arbiter
   import mem_fifo_pkg::*, arb_client_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // DDR2 FIFO status
   input  logic       i_af_full,
   input  logic       i_wdf_full,
   input  logic       i_rdf_valid,
   // client requests
   input  cache_req_t i_icache_req,
   input  cache_req_t i_dcache_req,
   input  pixel_req_t i_pixel_req,
   input  line_req_t  i_line_req,
   // client read enables
   input  logic       i_icache_rdf_rd_en,
   input  logic       i_dcache_rdf_rd_en,
   input  logic       i_pixel_rdf_rd_en,
   // to the DDR2 FIFOs
   output ddr_cmd_t   o_cmd,
   output logic       o_af_wr_en,
   output ddr_wdata_t o_wdata,
   output logic       o_wdf_wr_en,
   output logic       o_rdf_rd_en,
   // per-client full flags
   output logic       o_icache_full,
   output logic       o_dcache_full,
   output logic       o_pixel_full,
   output logic       o_line_full,
   // per-client read valids
   output logic       o_icache_rdf_valid,
   output logic       o_dcache_rdf_valid,
   output logic       o_pixel_rdf_valid
);

   // grant and read issue pulse to the return side
   client_t grant;
   logic    read_issued;

   fifo_grant_select fifo_grant_select_inst (
      .clk           (clk),
      .rst           (rst),
      .i_af_full     (i_af_full),
      .i_wdf_full    (i_wdf_full),
      .i_icache_req  (i_icache_req),
      .i_dcache_req  (i_dcache_req),
      .i_pixel_req   (i_pixel_req),
      .i_line_req    (i_line_req),
      .o_grant       (grant),
      .o_cmd         (o_cmd),
      .o_af_wr_en    (o_af_wr_en),
      .o_wdata       (o_wdata),
      .o_wdf_wr_en   (o_wdf_wr_en),
      .o_read_issued (read_issued),
      .o_icache_full (o_icache_full),
      .o_dcache_full (o_dcache_full),
      .o_pixel_full  (o_pixel_full),
      .o_line_full   (o_line_full)
   );

   read_return_router read_return_router_inst (
      .clk                (clk),
      .rst                (rst),
      .i_grant            (grant),
      .i_read_issued      (read_issued),
      .i_rdf_valid        (i_rdf_valid),
      .o_rdf_rd_en        (o_rdf_rd_en),
      .i_icache_rdf_rd_en (i_icache_rdf_rd_en),
      .i_dcache_rdf_rd_en (i_dcache_rdf_rd_en),
      .i_pixel_rdf_rd_en  (i_pixel_rdf_rd_en),
      .o_icache_rdf_valid (o_icache_rdf_valid),
      .o_dcache_rdf_valid (o_dcache_rdf_valid),
      .o_pixel_rdf_valid  (o_pixel_rdf_valid)
   );

endmodule

// ==== tb/ddr_request_arbiter_assertions.sv ====
// Grant select checks
`timescale 1ns/1ps

module ddr_request_arbiter_assertions
   import arb_client_pkg::*;
(
   input logic    clk,
   input logic    rst,
   input logic    i_af_full,
   input logic    i_wdf_full,
   input logic    o_af_wr_en,
   input logic    o_wdf_wr_en,
   input logic    o_icache_full,
   input logic    o_dcache_full,
   input logic    o_pixel_full,
   input logic    o_line_full,
   input client_t o_grant,
   input logic    line_rsv
);

   // **************************************************
   // FIFO safety
   // **************************************************

   // a full FIFO never sees an enable
   assert property (@(posedge clk) disable iff (rst)
      (i_af_full || i_wdf_full) |-> !(o_af_wr_en || o_wdf_wr_en))
      else $error("write enable raised while a FIFO is full");

   // **************************************************
   // grant exclusivity
   // **************************************************

   // at most one client sees room
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({!o_icache_full, !o_dcache_full, !o_pixel_full, !o_line_full}))
      else $error("more than one client full flag low");

   // open line burst keeps everyone else out
   assert property (@(posedge clk) disable iff (rst)
      line_rsv |-> (o_grant == LINE || o_grant == NONE))
      else $error("non-line grant during line reservation");

endmodule

bind fifo_grant_select ddr_request_arbiter_assertions assertions_inst (
   .clk           (clk),
   .rst           (rst),
   .i_af_full     (i_af_full),
   .i_wdf_full    (i_wdf_full),
   .o_af_wr_en    (o_af_wr_en),
   .o_wdf_wr_en   (o_wdf_wr_en),
   .o_icache_full (o_icache_full),
   .o_dcache_full (o_dcache_full),
   .o_pixel_full  (o_pixel_full),
   .o_line_full   (o_line_full),
   .o_grant       (o_grant),
   .line_rsv      (line_rsv)
);

// ==== tb/ddr_request_arbiter_tb.sv ====
// DDR2 request arbiter testbench
`timescale 1ns/1ps

module ddr_request_arbiter_tb
   import mem_fifo_pkg::*, arb_client_pkg::*;
();

   localparam int MAX_VEC = 64;
   localparam logic [31:0] END_VEC = 32'hffff_ffff;

   logic       clk;
   logic       rst;
   logic       af_full;
   logic       wdf_full;
   logic       rdf_valid;
   cache_req_t icache_req;
   cache_req_t dcache_req;
   pixel_req_t pixel_req;
   line_req_t  line_req;
   logic       icache_rd_en;
   logic       dcache_rd_en;
   logic       pixel_rd_en;
   ddr_cmd_t   cmd;
   logic       af_wr_en;
   ddr_wdata_t wdata;
   logic       wdf_wr_en;
   logic       rdf_rd_en;
   logic       icache_full;
   logic       dcache_full;
   logic       pixel_full;
   logic       line_full;
   logic       icache_valid;
   logic       dcache_valid;
   logic       pixel_valid;

   logic [31:0] vectors [0:MAX_VEC-1];
   logic [31:0] rng_state;
   int          cyc;
   int          last_due;
   // read FIFO model holds release cycle and owner per beat
   int          beat_due[$];
   client_t     beat_owner[$];

   ddr_request_arbiter ddr_request_arbiter_inst (
      .clk                (clk),
      .rst                (rst),
      .i_af_full          (af_full),
      .i_wdf_full         (wdf_full),
      .i_rdf_valid        (rdf_valid),
      .i_icache_req       (icache_req),
      .i_dcache_req       (dcache_req),
      .i_pixel_req        (pixel_req),
      .i_line_req         (line_req),
      .i_icache_rdf_rd_en (icache_rd_en),
      .i_dcache_rdf_rd_en (dcache_rd_en),
      .i_pixel_rdf_rd_en  (pixel_rd_en),
      .o_cmd              (cmd),
      .o_af_wr_en         (af_wr_en),
      .o_wdata            (wdata),
      .o_wdf_wr_en        (wdf_wr_en),
      .o_rdf_rd_en        (rdf_rd_en),
      .o_icache_full      (icache_full),
      .o_dcache_full      (dcache_full),
      .o_pixel_full       (pixel_full),
      .o_line_full        (line_full),
      .o_icache_rdf_valid (icache_valid),
      .o_dcache_rdf_valid (dcache_valid),
      .o_pixel_rdf_valid  (pixel_valid)
   );

   always #4 clk = ~clk;

   // xorshift32 for addresses, data and read order
   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic ddr_wdata_t random_wdata();
      ddr_wdata_t w;
      w.data = {next_random(), next_random(), next_random(), next_random()};
      w.mask = MASK_W'(next_random());
      return w;
   endfunction

   task automatic check_value(input logic [191:0] got, input logic [191:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("Error: %0t: %s is %0h, expected %0h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   // **************************************************
   // one cycle of stimulus and checks
   // **************************************************

   // hex digits from the top are icache dcache pixel line af_full wdf_full 0 grant
   task automatic run_cycle(input logic [31:0] vec, input client_t exp_grant);
      cache_req_t ic;
      cache_req_t dc;
      pixel_req_t px;
      line_req_t  ln;
      logic       ok;
      logic       exp_af;
      logic       exp_wdf;
      ddr_cmd_t   exp_cmd;
      ddr_wdata_t exp_wdata;
      logic       beat;
      logic [2:0] rd_ens;
      client_t    owner;
      logic       exp_rd_en;
      int         t;
      ic.af_wr_en  = vec[30];
      ic.wdf_wr_en = vec[29];
      ic.cmd.cmd   = vec[28] ? CMD_READ : CMD_WRITE;
      ic.cmd.addr  = ADDR_W'(next_random());
      ic.wdata     = random_wdata();
      dc.af_wr_en  = vec[26];
      dc.wdf_wr_en = vec[25];
      dc.cmd.cmd   = vec[24] ? CMD_READ : CMD_WRITE;
      dc.cmd.addr  = ADDR_W'(next_random());
      dc.wdata     = random_wdata();
      px.af_wr_en  = vec[20];
      px.addr      = ADDR_W'(next_random());
      ln.af_wr_en  = vec[17];
      ln.wdf_wr_en = vec[16];
      ln.addr      = ADDR_W'(next_random());
      ln.wdata     = random_wdata();
      rd_ens       = 3'(next_random() >> 29);
      @(posedge clk);
      cyc++;
      beat = (beat_due.size() > 0) && (beat_due[0] <= cyc);
      if (beat) begin
         void'(beat_due.pop_front());
      end
      icache_req   <= ic;
      dcache_req   <= dc;
      pixel_req    <= px;
      line_req     <= ln;
      af_full      <= vec[12];
      wdf_full     <= vec[8];
      rdf_valid    <= beat;
      icache_rd_en <= rd_ens[2];
      dcache_rd_en <= rd_ens[1];
      pixel_rd_en  <= rd_ens[0];
      #2;
      check_value(192'(ddr_request_arbiter_inst.grant), 192'(exp_grant), "grant");
      ok        = !vec[12] && !vec[8];
      exp_af    = 1'b0;
      exp_wdf   = 1'b0;
      exp_cmd   = ic.cmd;
      exp_wdata = ic.wdata;
      case (exp_grant)
         ICACHE: begin
            exp_af  = ic.af_wr_en;
            exp_wdf = ic.wdf_wr_en;
         end
         DCACHE: begin
            exp_af    = dc.af_wr_en;
            exp_wdf   = dc.wdf_wr_en;
            exp_cmd   = dc.cmd;
            exp_wdata = dc.wdata;
         end
         PIXEL: begin
            // read with nothing to write
            exp_af         = px.af_wr_en;
            exp_cmd.cmd    = CMD_READ;
            exp_cmd.addr   = px.addr;
            exp_wdata.data = '0;
            exp_wdata.mask = '1;
         end
         LINE: begin
            exp_af       = ln.af_wr_en;
            exp_wdf      = ln.wdf_wr_en;
            exp_cmd.cmd  = CMD_WRITE;
            exp_cmd.addr = ln.addr;
            exp_wdata    = ln.wdata;
         end
         default: begin
         end
      endcase
      exp_af  = exp_af && ok;
      exp_wdf = exp_wdf && ok;
      check_value(192'(icache_full), 192'(!(exp_grant == ICACHE && ok)), "icache full");
      check_value(192'(dcache_full), 192'(!(exp_grant == DCACHE && ok)), "dcache full");
      check_value(192'(pixel_full), 192'(!(exp_grant == PIXEL && ok)), "pixel full");
      check_value(192'(line_full), 192'(!(exp_grant == LINE && ok)), "line full");
      check_value(192'(af_wr_en), 192'(exp_af), "address FIFO enable");
      check_value(192'(wdf_wr_en), 192'(exp_wdf), "data FIFO enable");
      if (exp_af || exp_wdf) begin
         check_value(192'(cmd), 192'(exp_cmd), "command");
         check_value(192'(wdata), 192'(exp_wdata), "write data");
      end
      // read return owner comes from the in-order queue
      owner = NONE;
      if (beat) begin
         owner = beat_owner.pop_front();
      end
      check_value(192'(icache_valid), 192'(beat && owner == ICACHE), "icache read valid");
      check_value(192'(dcache_valid), 192'(beat && owner == DCACHE), "dcache read valid");
      check_value(192'(pixel_valid), 192'(beat && owner == PIXEL), "pixel read valid");
      if (beat) begin
         exp_rd_en = (owner == ICACHE) ? rd_ens[2] :
                     (owner == DCACHE) ? rd_ens[1] : rd_ens[0];
         check_value(192'(rdf_rd_en), 192'(exp_rd_en), "read FIFO read enable");
      end
      if (exp_af && exp_cmd.cmd == CMD_READ) begin
         // a cache holds one ticket so its older beats fall to pixel
         foreach (beat_owner[i]) begin
            if (exp_grant != PIXEL && beat_owner[i] == exp_grant) begin
               beat_owner[i] = PIXEL;
            end
         end
         t = cyc + 3;
         if (last_due >= t) begin
            t = last_due + 1;
         end
         beat_due.push_back(t);
         beat_due.push_back(t + 1);
         beat_owner.push_back(exp_grant);
         beat_owner.push_back(exp_grant);
         last_due = t + 1;
      end
   endtask

   // **************************************************
   // main sequence
   // **************************************************

   initial begin
      int      idx;
      int      wait_cnt;
      logic [31:0] pick;
      clk          = 1'b0;
      rst          = 1'b1;
      af_full      = 1'b0;
      wdf_full     = 1'b0;
      rdf_valid    = 1'b0;
      icache_req   = '0;
      dcache_req   = '0;
      pixel_req    = '0;
      line_req     = '0;
      icache_rd_en = 1'b0;
      dcache_rd_en = 1'b0;
      pixel_rd_en  = 1'b0;
      rng_state    = 32'd95896;
      cyc          = 0;
      last_due     = 0;
      for (idx = 0; idx < MAX_VEC; idx++) begin
         vectors[idx] = END_VEC;
      end
      $readmemh("tb/arb_tests.mem", vectors);
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      // directed vectors from the file
      idx = 0;
      while (idx < MAX_VEC && vectors[idx] != END_VEC) begin
         run_cycle(vectors[idx], client_t'(vectors[idx][2:0]));
         idx++;
      end
      // reads in random client order with idle gaps
      for (idx = 0; idx < 24; idx++) begin
         pick = next_random();
         case (pick % 3)
            0: run_cycle(32'h5000_0000, ICACHE);
            1: run_cycle(32'h0500_0000, DCACHE);
            default: run_cycle(32'h0010_0000, PIXEL);
         endcase
         if (pick[8]) begin
            run_cycle(32'h0, NONE);
         end
      end
      // let the read FIFO model drain
      wait_cnt = 0;
      while (beat_due.size() > 0 && wait_cnt < 100) begin
         run_cycle(32'h0, NONE);
         wait_cnt++;
      end
      if (beat_due.size() > 0) begin
         $display("timeout: read beats still pending after the drain");
         $display("SIMULATION FAILED");
         $fatal(1, "drain timeout");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

// ==== tb/arb_tests.mem ====
// digits: icache dcache pixel line af_full wdf_full 0 grant
// cache 5 read, 6 write; pixel 1 read; line 3 both beats enables
00000000
55130001
06130002
00130003
00030004
50030004
50000001
60001001
60000101
60000001
00031004
00030004
50000000
50030004
50000001
05000002
00100003
66000001
00000000
00000000

// ==== all.f ====
logic/mem_fifo_pkg.sv
logic/arb_client_pkg.sv
logic/fifo_grant_select.sv
logic/read_ticket.sv
logic/read_return_router.sv
logic/ddr_request_arbiter.sv
tb/ddr_request_arbiter_assertions.sv
tb/ddr_request_arbiter_tb.sv

// ==== Makefile ====
# Verilator flow for the DDR2 request arbiter

VERILATOR ?= verilator
FLIST     ?= all.f
TB_TOP    ?= ddr_request_arbiter_tb
RTL_TOP   ?= ddr_request_arbiter
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
